// ==== board_bus_pkg.sv ====
`default_nettype none

package board_bus_pkg;

    // bus side widths
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // ram side widths
    typedef logic [31:0] word_t;
    typedef logic [9:0]  ram_index_t;
    typedef logic [3:0]  lane_mask_t;

    // bit 2 set means unsigned load, low bits give the size
    typedef logic [2:0]  ls_type_t;

    // ascii code from the keyboard decoder
    typedef logic [7:0]  key_code_t;

    // size field of ls_type
    localparam logic [1:0] SIZE_BYTE   = 2'd0;
    localparam logic [1:0] SIZE_HALF   = 2'd1;
    localparam logic [1:0] SIZE_WORD   = 2'd2;
    localparam logic [1:0] SIZE_DOUBLE = 2'd3;

    // address map
    localparam addr_t RAM_BASE     = 64'h1000;
    localparam int    RAM_WORDS    = 1024;
    localparam addr_t RAM_LIMIT    = RAM_BASE + addr_t'(RAM_WORDS * 4);
    localparam addr_t KEY_ADDR     = 64'h3000;
    localparam addr_t CONSOLE_ADDR = 64'h3008;

    // one processor request
    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        ls_type_t ls_type;
        logic     write;
    } bus_req_t;

    typedef enum logic [2:0] {
        IDLE,
        RAM_RD,
        RAM_RD_HI,
        RAM_WR_HI,
        CONSOLE_WAIT,
        RESPOND
    } bus_fsm_state_t;

endpackage

`default_nettype wire

// ==== word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_ram (
    input  wire                            CLOCK_50,
    input  wire board_bus_pkg::ram_index_t index,
    input  wire                            we,
    input  wire board_bus_pkg::lane_mask_t mask,
    input  wire board_bus_pkg::word_t      wdata,
    output board_bus_pkg::word_t           rdata
);
    import board_bus_pkg::*;

    // no init, contents start undefined
    word_t mem [RAM_WORDS];

    // byte lane writes
    always_ff @(posedge CLOCK_50) begin
        if (we) begin
            for (int lane = 0; lane < $bits(lane_mask_t); lane++) begin
                if (mask[lane]) begin
                    mem[index][8*lane +: 8] <= wdata[8*lane +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge CLOCK_50) begin
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== lane_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_align (
    input  wire board_bus_pkg::bus_req_t beat_req,
    input  wire                          hi_beat,
    input  wire board_bus_pkg::word_t    ram_rdata,
    input  wire board_bus_pkg::word_t    low_word,
    output board_bus_pkg::word_t         store_word,
    output board_bus_pkg::lane_mask_t    store_mask,
    output board_bus_pkg::data_t         load_value
);
    import board_bus_pkg::*;

    logic [1:0] size;
    logic [1:0] offset;
    logic       is_unsigned;
    word_t      shifted;

    assign size        = beat_req.ls_type[1:0];
    assign is_unsigned = beat_req.ls_type[2];
    assign offset      = beat_req.addr[1:0];

    // bring the addressed lane down to bit 0
    assign shifted = ram_rdata >> {offset, 3'b000};

    // store side, copy data to every lane and let the mask pick
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                store_word = {4{beat_req.wdata[7:0]}};
                store_mask = lane_mask_t'(4'b0001 << offset);
            end
            SIZE_HALF: begin
                store_word = {2{beat_req.wdata[15:0]}};
                store_mask = lane_mask_t'(4'b0011 << offset);
            end
            SIZE_WORD: begin
                store_word = beat_req.wdata[31:0];
                store_mask = 4'b1111;
            end
            default: begin
                // double, upper half goes out on the second beat
                store_word = hi_beat ? beat_req.wdata[63:32] : beat_req.wdata[31:0];
                store_mask = 4'b1111;
            end
        endcase
    end

    // load side, sign or zero extend by type
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                load_value = is_unsigned ? data_t'(shifted[7:0])
                                         : {{56{shifted[7]}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                load_value = is_unsigned ? data_t'(shifted[15:0])
                                         : {{48{shifted[15]}}, shifted[15:0]};
            end
            SIZE_WORD: begin
                load_value = is_unsigned ? data_t'(shifted)
                                         : {{32{shifted[31]}}, shifted};
            end
            default: begin
                // high word just read, low word held by the fsm
                load_value = {ram_rdata, low_word};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== key_irq_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_irq_unit (
    input  wire                           CLOCK_50,
    input  wire                           KEY0,
    input  wire                           key_valid,
    input  wire board_bus_pkg::key_code_t key_code,
    input  wire                           irq_ack,
    output board_bus_pkg::key_code_t      key_latched,
    output logic                          irq
);
    import board_bus_pkg::*;

    logic key_event;

    // zero code is a release or a no-op from the decoder
    assign key_event = key_valid && (key_code != key_code_t'(0));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_latched <= '0;
        end else if (key_event) begin
            key_latched <= key_code;
        end
    end

    // new key beats the ack in the same cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq <= 1'b0;
        end else if (key_event) begin
            irq <= 1'b1;
        end else if (irq_ack) begin
            irq <= 1'b0;
        end
    end

    // processor only acks a raised line
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_ack |-> irq);

endmodule

`default_nettype wire

// ==== bus_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_fsm (
    input  wire                          CLOCK_50,
    input  wire                          KEY0,
    input  wire                          req_valid,
    input  wire board_bus_pkg::bus_req_t req,
    output logic                         req_ready,
    output logic                         rsp_valid,
    output board_bus_pkg::data_t         rsp_data,
    input  wire                          rsp_ready,
    output logic                         console_valid,
    output board_bus_pkg::key_code_t     console_data,
    input  wire                          console_ready,
    input  wire board_bus_pkg::key_code_t key_latched,
    input  wire board_bus_pkg::word_t    ram_rdata,
    input  wire board_bus_pkg::word_t    store_word,
    input  wire board_bus_pkg::lane_mask_t store_mask,
    input  wire board_bus_pkg::data_t    load_value,
    output board_bus_pkg::ram_index_t    ram_index,
    output logic                         ram_we,
    output board_bus_pkg::lane_mask_t    ram_mask,
    output board_bus_pkg::word_t         ram_wdata,
    output board_bus_pkg::bus_req_t      beat_req,
    output logic                         hi_beat,
    output board_bus_pkg::word_t         low_word
);
    import board_bus_pkg::*;

    bus_fsm_state_t state;
    bus_fsm_state_t state_next;
    bus_req_t       req_q;
    logic           accept;
    logic           req_is_double;
    ram_index_t     base_index;

    function automatic logic is_ram(input addr_t addr);
        return (addr >= RAM_BASE) && (addr < RAM_LIMIT);
    endfunction

    // word index inside the ram window
    function automatic ram_index_t word_of(input addr_t addr);
        addr_t offset;
        offset = addr - RAM_BASE;
        return offset[$bits(ram_index_t)+1:2];
    endfunction

    function automatic logic is_aligned(input addr_t addr, input ls_type_t ls);
        case (ls[1:0])
            SIZE_HALF:   return addr[0] == 1'b0;
            SIZE_WORD:   return addr[1:0] == 2'b00;
            SIZE_DOUBLE: return addr[2:0] == 3'b000;
            default:     return 1'b1;
        endcase
    endfunction

    // handshake side, all straight from the state
    assign req_ready     = (state == IDLE);
    assign accept        = req_valid && req_ready;
    assign rsp_valid     = (state == RESPOND);
    assign console_valid = (state == CONSOLE_WAIT);
    assign console_data  = req_q.wdata[7:0];

    // first beat runs off the incoming request, later beats off the held copy
    assign beat_req      = (state == IDLE) ? req : req_q;
    assign hi_beat       = (state == RAM_RD_HI) || (state == RAM_WR_HI);
    assign req_is_double = (req_q.ls_type[1:0] == SIZE_DOUBLE);

    // second word of a double sits one index up
    assign base_index = word_of(beat_req.addr);
    assign ram_index  = base_index + ram_index_t'((state == RAM_RD) || (state == RAM_WR_HI));
    assign ram_we     = (accept && req.write && is_ram(req.addr)) || (state == RAM_WR_HI);
    assign ram_mask   = store_mask;
    assign ram_wdata  = store_word;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    if (is_ram(req.addr)) begin
                        if (!req.write) begin
                            state_next = RAM_RD;
                        end else if (req.ls_type[1:0] == SIZE_DOUBLE) begin
                            state_next = RAM_WR_HI;
                        end else begin
                            state_next = RESPOND;
                        end
                    end else if (req.write && (req.addr == CONSOLE_ADDR)) begin
                        state_next = CONSOLE_WAIT;
                    end else begin
                        // key read, unmapped, or ignored write
                        state_next = RESPOND;
                    end
                end
            end
            RAM_RD: begin
                state_next = req_is_double ? RAM_RD_HI : RESPOND;
            end
            RAM_RD_HI, RAM_WR_HI: begin
                state_next = RESPOND;
            end
            CONSOLE_WAIT: begin
                // stall here until the console takes the byte
                if (console_ready) begin
                    state_next = RESPOND;
                end
            end
            RESPOND: begin
                if (rsp_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // held request, first half and response word
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req_q    <= req;
            rsp_data <= '0;
            if (!req.write && (req.addr == KEY_ADDR)) begin
                rsp_data <= data_t'(key_latched);
            end
        end
        if (state == RAM_RD) begin
            low_word <= ram_rdata;
        end
        // double overwrites this again in the high beat
        if ((state == RAM_RD) || (state == RAM_RD_HI)) begin
            rsp_data <= load_value;
        end
    end

    // requester must not hand ram a misaligned access
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        accept && is_ram(req.addr) |-> is_aligned(req.addr, req.ls_type));

    // response held until taken
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

`default_nettype wire

// ==== board_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_bus_top (
    input  wire                        CLOCK_50,
    input  wire                        KEY0,
    // request channel
    input  wire                        req_valid,
    input  wire board_bus_pkg::bus_req_t req,
    output logic                       req_ready,
    // response channel
    output logic                       rsp_valid,
    output board_bus_pkg::data_t       rsp_data,
    input  wire                        rsp_ready,
    // keyboard strobe and interrupt
    input  wire                        key_valid,
    input  wire board_bus_pkg::key_code_t key_code,
    input  wire                        irq_ack,
    output logic                       irq,
    // console byte out
    output logic                       console_valid,
    output board_bus_pkg::key_code_t   console_data,
    input  wire                        console_ready
);
    import board_bus_pkg::*;

    // fsm to ram
    ram_index_t ram_index;
    logic       ram_we;
    lane_mask_t ram_mask;
    word_t      ram_wdata;
    word_t      ram_rdata;

    // fsm to lane logic and back
    bus_req_t   beat_req;
    logic       hi_beat;
    word_t      low_word;
    word_t      store_word;
    lane_mask_t store_mask;
    data_t      load_value;

    key_code_t  key_latched;

    bus_fsm fsm_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_ready     (rsp_ready),
        .console_valid (console_valid),
        .console_data  (console_data),
        .console_ready (console_ready),
        .key_latched   (key_latched),
        .ram_rdata     (ram_rdata),
        .store_word    (store_word),
        .store_mask    (store_mask),
        .load_value    (load_value),
        .ram_index     (ram_index),
        .ram_we        (ram_we),
        .ram_mask      (ram_mask),
        .ram_wdata     (ram_wdata),
        .beat_req      (beat_req),
        .hi_beat       (hi_beat),
        .low_word      (low_word)
    );

    word_ram ram_i (
        .CLOCK_50 (CLOCK_50),
        .index    (ram_index),
        .we       (ram_we),
        .mask     (ram_mask),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

    lane_align align_i (
        .beat_req   (beat_req),
        .hi_beat    (hi_beat),
        .ram_rdata  (ram_rdata),
        .low_word   (low_word),
        .store_word (store_word),
        .store_mask (store_mask),
        .load_value (load_value)
    );

    key_irq_unit key_i (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .irq_ack     (irq_ack),
        .key_latched (key_latched),
        .irq         (irq)
    );

endmodule

`default_nettype wire

// ==== tb_board_bus_table.svh ====
`ifndef TB_BOARD_BUS_TABLE_SVH
`define TB_BOARD_BUS_TABLE_SVH

// op, address, ls_type, write data or key code, expected read data, expected irq
// ls_type 0 byte, 1 half, 2 word, 3 double, plus 4 for unsigned loads
task automatic fill_table();
    stim[0]  = '{OP_WRITE, 64'h1000, 3'd2, 64'h0000_0000_1234_5678, 64'h0, 1'b0};
    stim[1]  = '{OP_WRITE, 64'h1008, 3'd3, 64'h89ab_cdef_0123_4567, 64'h0, 1'b0};
    stim[2]  = '{OP_READ,  64'h1008, 3'd3, 64'h0, 64'h89ab_cdef_0123_4567, 1'b0};
    stim[3]  = '{OP_READ,  64'h100c, 3'd6, 64'h0, 64'h0000_0000_89ab_cdef, 1'b0};
    stim[4]  = '{OP_READ,  64'h100c, 3'd2, 64'h0, 64'hffff_ffff_89ab_cdef, 1'b0};
    // byte lanes 0, 1 and 3 over a known word
    stim[5]  = '{OP_WRITE, 64'h1010, 3'd2, 64'h0000_0000_1122_3344, 64'h0, 1'b0};
    stim[6]  = '{OP_WRITE, 64'h1010, 3'd0, 64'h0000_0000_0000_00aa, 64'h0, 1'b0};
    stim[7]  = '{OP_WRITE, 64'h1011, 3'd0, 64'h0000_0000_0000_0066, 64'h0, 1'b0};
    stim[8]  = '{OP_WRITE, 64'h1013, 3'd0, 64'hffff_ffff_ffff_ff99, 64'h0, 1'b0};
    stim[9]  = '{OP_READ,  64'h1010, 3'd2, 64'h0, 64'hffff_ffff_9922_66aa, 1'b0};
    // both halves, then byte lane 2
    stim[10] = '{OP_WRITE, 64'h1018, 3'd2, 64'h0000_0000_1234_5678, 64'h0, 1'b0};
    stim[11] = '{OP_WRITE, 64'h101a, 3'd1, 64'h0000_0000_0000_cafe, 64'h0, 1'b0};
    stim[12] = '{OP_WRITE, 64'h1018, 3'd1, 64'h0000_0000_0000_beef, 64'h0, 1'b0};
    stim[13] = '{OP_WRITE, 64'h101a, 3'd0, 64'h0000_0000_0000_00c3, 64'h0, 1'b0};
    stim[14] = '{OP_READ,  64'h1018, 3'd6, 64'h0, 64'h0000_0000_cac3_beef, 1'b0};
    stim[15] = '{OP_READ,  64'h1019, 3'd0, 64'h0, 64'hffff_ffff_ffff_ffbe, 1'b0};
    stim[16] = '{OP_READ,  64'h101b, 3'd4, 64'h0, 64'h0000_0000_0000_00ca, 1'b0};
    stim[17] = '{OP_READ,  64'h101a, 3'd1, 64'h0, 64'hffff_ffff_ffff_cac3, 1'b0};
    stim[18] = '{OP_READ,  64'h1018, 3'd5, 64'h0, 64'h0000_0000_0000_beef, 1'b0};
    // console gets 0x41
    stim[19] = '{OP_WRITE, 64'h3008, 3'd0, 64'h0000_0000_1234_5641, 64'h0, 1'b0};
    stim[20] = '{OP_KEY,   64'h0,    3'd0, 64'h61, 64'h0, 1'b1};
    stim[21] = '{OP_READ,  64'h3000, 3'd2, 64'h0, 64'h61, 1'b1};
    stim[22] = '{OP_ACK,   64'h0,    3'd0, 64'h0, 64'h0, 1'b0};
    stim[23] = '{OP_KEY,   64'h0,    3'd0, 64'h00, 64'h0, 1'b0};
    // 0x2000 would land on ram word 0 if decoded wrongly
    stim[24] = '{OP_READ,  64'h2000, 3'd2, 64'h0, 64'h0, 1'b0};
    stim[25] = '{OP_WRITE, 64'h2000, 3'd2, 64'h0000_0000_ffff_ffff, 64'h0, 1'b0};
    stim[26] = '{OP_READ,  64'h1000, 3'd2, 64'h0, 64'h0000_0000_1234_5678, 1'b0};
endtask

`endif

// ==== tb_board_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_bus;
    import board_bus_pkg::*;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_KEY,
        OP_ACK
    } op_t;

    // key strobes carry their code in the low byte of wdata
    typedef struct packed {
        op_t      op;
        addr_t    addr;
        ls_type_t ls_type;
        data_t    wdata;
        data_t    exp_data;
        logic     exp_irq;
    } entry_t;

    localparam int N_ENTRIES    = 27;
    localparam int RESET_CYCLES = 16;
    // worst entry stays well under 20 cycles even with full back-pressure
    localparam int CYCLE_LIMIT  = 20 * N_ENTRIES + RESET_CYCLES;

    logic      CLOCK_50 = 1'b0;
    logic      KEY0;
    logic      req_valid;
    bus_req_t  req;
    logic      req_ready;
    logic      rsp_valid;
    data_t     rsp_data;
    logic      rsp_ready;
    logic      key_valid;
    key_code_t key_code;
    logic      irq_ack;
    logic      irq;
    logic      console_valid;
    key_code_t console_data;
    logic      console_ready;

    entry_t      stim [N_ENTRIES];
    logic [31:0] lcg_state   = 32'h86e;
    int          cycle_count = 0;

    `include "tb_board_bus_table.svh"

    board_bus_top dut_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_ready     (rsp_ready),
        .key_valid     (key_valid),
        .key_code      (key_code),
        .irq_ack       (irq_ack),
        .irq           (irq),
        .console_valid (console_valid),
        .console_data  (console_data),
        .console_ready (console_ready)
    );

    // 100 ns period
    always #50 CLOCK_50 = ~CLOCK_50;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_error($sformatf("timeout after %0d cycles, the bus stopped responding",
                                      cycle_count));
        end
    end

    // lcg step, upper bits give a value of 0..3
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:29]);
    endfunction

    // inputs change 5 ns after the edge, outputs are settled by then
    task automatic tick();
        @(posedge CLOCK_50);
        #5;
    endtask

    task automatic run_access(input int idx, input entry_t e);
        int    rsp_hold;
        int    con_hold;
        int    handshakes;
        int    exp_handshakes;
        logic  hs;
        logic  rsp_seen;
        logic  done;
        data_t first_data;
        exp_handshakes = (e.op == OP_WRITE && e.addr == CONSOLE_ADDR) ? 1 : 0;
        while (!req_ready) begin
            tick();
        end
        req_valid = 1'b1;
        req = '{addr: e.addr, wdata: e.wdata, ls_type: e.ls_type, write: (e.op == OP_WRITE)};
        tick();
        req_valid = 1'b0;
        // every access sees at least one cycle of back-pressure
        rsp_hold = 1 + next_delay();
        con_hold = 1 + next_delay();
        handshakes = 0;
        rsp_seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            hs = 1'b0;
            console_ready = 1'b0;
            if (console_valid) begin
                assert (console_data == e.wdata[7:0]) else stop_with_error($sformatf(
                    "[FAIL] %0t: entry %0d console byte 0x%h, expected 0x%h",
                    $time, idx, console_data, e.wdata[7:0]));
                if (con_hold > 0) begin
                    con_hold--;
                end else begin
                    console_ready = 1'b1;
                    hs = 1'b1;
                end
            end
            rsp_ready = 1'b0;
            if (rsp_valid) begin
                if (!rsp_seen) begin
                    first_data = rsp_data;
                    rsp_seen = 1'b1;
                end
                // held response must not move and no new request may enter
                assert (rsp_data == first_data && !req_ready) else stop_with_error($sformatf(
                    "[FAIL] %0t: entry %0d response moved to 0x%h or req_ready high",
                    $time, idx, rsp_data));
                if (rsp_hold > 0) begin
                    rsp_hold--;
                end else begin
                    rsp_ready = 1'b1;
                    done = 1'b1;
                end
            end
            tick();
            if (hs) begin
                handshakes++;
            end
        end
        rsp_ready = 1'b0;
        console_ready = 1'b0;
        assert (first_data == e.exp_data) else stop_with_error($sformatf(
            "[FAIL] %0t: entry %0d addr 0x%h read 0x%h, expected 0x%h",
            $time, idx, e.addr, first_data, e.exp_data));
        assert (handshakes == exp_handshakes) else stop_with_error($sformatf(
            "[FAIL] %0t: entry %0d saw %0d console bytes, expected %0d",
            $time, idx, handshakes, exp_handshakes));
    endtask

    initial begin
        KEY0 = 1'b0;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        key_valid = 1'b0;
        key_code = '0;
        irq_ack = 1'b0;
        console_ready = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #5;
        assert (!rsp_valid && !console_valid && !irq) else
            stop_with_error("response, console or interrupt output was high during reset");
        KEY0 = 1'b1;
        tick();
        assert (req_ready) else stop_with_error("req_ready did not rise after reset");
        for (int i = 0; i < N_ENTRIES; i++) begin
            case (stim[i].op)
                OP_KEY: begin
                    key_valid = 1'b1;
                    key_code = stim[i].wdata[7:0];
                    tick();
                    key_valid = 1'b0;
                    key_code = '0;
                end
                OP_ACK: begin
                    irq_ack = 1'b1;
                    tick();
                    irq_ack = 1'b0;
                end
                default: begin
                    run_access(i, stim[i]);
                end
            endcase
            assert (irq == stim[i].exp_irq) else stop_with_error($sformatf(
                "[FAIL] %0t: entry %0d irq %b, expected %b", $time, i, irq, stim[i].exp_irq));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
board_bus_pkg.sv
word_ram.sv
lane_align.sv
key_irq_unit.sv
bus_fsm.sv
board_bus_top.sv
tb_board_bus.sv

// ==== Bender.yml ====
package:
  name: board_bus

sources:
  - board_bus_pkg.sv
  - word_ram.sv
  - lane_align.sv
  - key_irq_unit.sv
  - bus_fsm.sv
  - board_bus_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_board_bus.sv
